//--- hdl/tomasuloPkg.sv
`default_nettype none

package tomasuloPkg;

	localparam int DATA_WIDTH = 16;
	localparam int HALF_WIDTH = DATA_WIDTH / 2;
	localparam int NUM_REGS = 8;
	localparam int REG_BITS = 3;
	localparam int NUM_STATIONS = 4; // also the credit count at reset
	localparam int TAG_BITS = 2;

	typedef logic [1:0] opCode;
	typedef logic [DATA_WIDTH-1:0] dataWord;
	typedef logic [HALF_WIDTH-1:0] halfWord;
	typedef logic [REG_BITS-1:0] regIndex;
	typedef logic [TAG_BITS-1:0] stationTag; // entry index

	localparam opCode OP_ADD = 2'd0;
	localparam opCode OP_SUB = 2'd1;
	localparam opCode OP_MUL = 2'd2;
	localparam opCode OP_ADDI = 2'd3;

	typedef struct packed {
		opCode op;
		regIndex rd;
		regIndex rs;
		regIndex rt;
		logic [4:0] unused;
	} rTypeWord;

	typedef struct packed {
		opCode op;
		regIndex rd;
		regIndex rs;
		logic [7:0] imm; // zero-extended
	} iTypeWord;

	typedef union packed {
		rTypeWord rType;
		iTypeWord iType;
	} instrWord;

	// value when ready, otherwise the tag to wait on
	typedef struct packed {
		logic ready;
		stationTag tag;
		dataWord value;
	} operand;

	typedef struct packed {
		logic valid;
		stationTag tag;
		opCode op;
		regIndex rd;
		operand srcA;
		operand srcB;
	} issuePacket;

	typedef struct packed {
		logic valid;
		stationTag tag;
		opCode op;
		regIndex rd;
		dataWord a;
		dataWord b;
	} execPacket;

	typedef struct packed {
		logic valid;
		stationTag tag;
		regIndex rd;
		dataWord value;
	} cdbResult;

endpackage

`default_nettype wire

//--- hdl/issueRename.sv
`default_nettype none

module issueRename (
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire tomasuloPkg::instrWord instr,
	input wire [tomasuloPkg::NUM_STATIONS-1:0] freeMask,
	input wire tomasuloPkg::cdbResult cdb,
	output tomasuloPkg::issuePacket issue,
	input wire tomasuloPkg::regIndex regAddr,
	output tomasuloPkg::dataWord regData
);

	tomasuloPkg::dataWord regFile [tomasuloPkg::NUM_REGS];
	logic [tomasuloPkg::NUM_REGS-1:0] aliasBusy;
	tomasuloPkg::stationTag aliasTag [tomasuloPkg::NUM_REGS];

	tomasuloPkg::opCode op;
	tomasuloPkg::regIndex rd;
	logic [tomasuloPkg::NUM_STATIONS-1:0] availMask;
	tomasuloPkg::stationTag allocTag;
	tomasuloPkg::issuePacket nextIssue;
	logic busWrite;

	// register file, renamed tag, or the result on the bus this cycle
	function automatic tomasuloPkg::operand readOperand(input tomasuloPkg::regIndex r);
		tomasuloPkg::operand o;
		o.ready = 1'b1;
		o.tag = aliasTag[r];
		o.value = regFile[r];
		if (aliasBusy[r]) begin
			if (cdb.valid && cdb.tag == aliasTag[r]) begin
				o.value = cdb.value;
			end else begin
				o.ready = 1'b0;
			end
		end
		return o;
	endfunction

	assign op = instr.rType.op;
	assign rd = instr.rType.rd;

	always_comb begin
		availMask = freeMask;
		if (issue.valid) begin
			availMask[issue.tag] = 1'b0; // still in flight to the station
		end
		allocTag = '0;
		for (int i = tomasuloPkg::NUM_STATIONS - 1; i >= 0; i--) begin
			if (availMask[i]) begin
				allocTag = i[tomasuloPkg::TAG_BITS-1:0];
			end
		end
	end

	always_comb begin
		nextIssue.valid = instrValid;
		nextIssue.tag = allocTag;
		nextIssue.op = op;
		nextIssue.rd = rd;
		nextIssue.srcA = readOperand(instr.iType.rs);
		if (op == tomasuloPkg::OP_ADDI) begin
			nextIssue.srcB.ready = 1'b1;
			nextIssue.srcB.tag = '0;
			nextIssue.srcB.value = tomasuloPkg::dataWord'(instr.iType.imm);
		end else begin
			nextIssue.srcB = readOperand(instr.rType.rt);
		end
	end

	// only the newest producer of a register may retire into it
	assign busWrite = cdb.valid && aliasBusy[cdb.rd] && aliasTag[cdb.rd] == cdb.tag;

	always_ff @(posedge clk) begin
		if (reset) begin
			issue.valid <= 1'b0;
		end else begin
			issue <= nextIssue;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < tomasuloPkg::NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
			aliasBusy <= '0;
		end else begin
			if (busWrite) begin
				regFile[cdb.rd] <= cdb.value;
				aliasBusy[cdb.rd] <= 1'b0;
			end
			if (instrValid) begin
				aliasBusy[rd] <= 1'b1; // overrides a same-cycle clear
				aliasTag[rd] <= allocTag;
			end
		end
	end

	assign regData = regFile[regAddr];

endmodule

`default_nettype wire

//--- hdl/resStation.sv
`default_nettype none

module resStation (
	input wire clk,
	input wire reset,
	input wire tomasuloPkg::issuePacket issue,
	input wire tomasuloPkg::cdbResult cdb,
	output logic [tomasuloPkg::NUM_STATIONS-1:0] freeMask,
	output tomasuloPkg::execPacket dispatch,
	output logic creditReturn
);

	typedef struct packed {
		logic busy;
		logic issued; // in the ALU, tag held until its result is broadcast
		tomasuloPkg::opCode op;
		tomasuloPkg::regIndex rd;
		tomasuloPkg::operand a;
		tomasuloPkg::operand b;
	} stationEntry;

	stationEntry entries [tomasuloPkg::NUM_STATIONS];
	logic [tomasuloPkg::NUM_STATIONS-1:0] readyMask;
	tomasuloPkg::stationTag pick;
	logic pickValid;

	// take the bus value when a waiting operand sees its tag
	function automatic tomasuloPkg::operand capture(input tomasuloPkg::operand o,
			input tomasuloPkg::cdbResult bus);
		tomasuloPkg::operand c;
		c = o;
		if (!o.ready && bus.valid && bus.tag == o.tag) begin
			c.ready = 1'b1;
			c.value = bus.value;
		end
		return c;
	endfunction

	always_comb begin
		for (int i = 0; i < tomasuloPkg::NUM_STATIONS; i++) begin
			freeMask[i] = !entries[i].busy;
			readyMask[i] = entries[i].busy && !entries[i].issued
				&& entries[i].a.ready && entries[i].b.ready;
		end
	end

	// lowest ready index wins
	always_comb begin
		pick = '0;
		for (int i = tomasuloPkg::NUM_STATIONS - 1; i >= 0; i--) begin
			if (readyMask[i]) begin
				pick = i[tomasuloPkg::TAG_BITS-1:0];
			end
		end
		pickValid = |readyMask;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < tomasuloPkg::NUM_STATIONS; i++) begin
				entries[i].busy <= 1'b0;
				entries[i].issued <= 1'b0;
			end
			dispatch.valid <= 1'b0;
			creditReturn <= 1'b0;
		end else begin
			for (int i = 0; i < tomasuloPkg::NUM_STATIONS; i++) begin
				entries[i].a <= capture(entries[i].a, cdb);
				entries[i].b <= capture(entries[i].b, cdb);
				if (entries[i].issued && cdb.valid && cdb.tag == i[tomasuloPkg::TAG_BITS-1:0]) begin
					entries[i].busy <= 1'b0;
					entries[i].issued <= 1'b0;
				end
			end
			if (issue.valid) begin
				entries[issue.tag] <= '{busy: 1'b1, issued: 1'b0, op: issue.op, rd: issue.rd,
					a: capture(issue.srcA, cdb), b: capture(issue.srcB, cdb)};
			end
			if (pickValid) begin
				entries[pick].issued <= 1'b1;
			end
			dispatch.valid <= pickValid;
			dispatch.tag <= pick;
			dispatch.op <= entries[pick].op;
			dispatch.rd <= entries[pick].rd;
			dispatch.a <= entries[pick].a.value;
			dispatch.b <= entries[pick].b.value;
			creditReturn <= cdb.valid && entries[cdb.tag].issued;
		end
	end

endmodule

`default_nettype wire

//--- hdl/aluPipe.sv
`default_nettype none

module aluPipe (
	input wire clk,
	input wire reset,
	input wire tomasuloPkg::execPacket dispatch,
	output tomasuloPkg::cdbResult result
);

	typedef struct packed {
		logic valid;
		tomasuloPkg::stationTag tag;
		tomasuloPkg::opCode op;
		tomasuloPkg::regIndex rd;
		tomasuloPkg::dataWord sum;
		tomasuloPkg::dataWord diff;
		tomasuloPkg::dataWord partLow; // a times low half of b
		tomasuloPkg::halfWord aLow;
		tomasuloPkg::halfWord bHigh;
	} stageOne;

	typedef struct packed {
		logic valid;
		tomasuloPkg::stationTag tag;
		tomasuloPkg::opCode op;
		tomasuloPkg::regIndex rd;
		tomasuloPkg::dataWord sum;
		tomasuloPkg::dataWord diff;
		tomasuloPkg::dataWord product;
	} stageTwo;

	stageOne s1;
	stageTwo s2;
	tomasuloPkg::dataWord selected;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1.valid <= 1'b0;
		end else begin
			s1.valid <= dispatch.valid;
			s1.tag <= dispatch.tag;
			s1.op <= dispatch.op;
			s1.rd <= dispatch.rd;
			s1.sum <= dispatch.a + dispatch.b;
			s1.diff <= dispatch.a - dispatch.b;
			s1.partLow <= dispatch.a * dispatch.b[tomasuloPkg::HALF_WIDTH-1:0];
			s1.aLow <= dispatch.a[tomasuloPkg::HALF_WIDTH-1:0];
			s1.bHigh <= dispatch.b[tomasuloPkg::DATA_WIDTH-1:tomasuloPkg::HALF_WIDTH];
		end
	end

	// upper cross term only reaches the top half of a truncated product
	always_ff @(posedge clk) begin
		if (reset) begin
			s2.valid <= 1'b0;
		end else begin
			s2.valid <= s1.valid;
			s2.tag <= s1.tag;
			s2.op <= s1.op;
			s2.rd <= s1.rd;
			s2.sum <= s1.sum;
			s2.diff <= s1.diff;
			s2.product <= s1.partLow + {s1.aLow * s1.bHigh, tomasuloPkg::halfWord'(0)};
		end
	end

	always_comb begin
		case (s2.op)
			tomasuloPkg::OP_SUB: selected = s2.diff;
			tomasuloPkg::OP_MUL: selected = s2.product;
			default: selected = s2.sum; // ADD and ADDI
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= s2.valid;
			result.tag <= s2.tag;
			result.rd <= s2.rd;
			result.value <= selected;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tomasuloCore.sv
`default_nettype none

module tomasuloCore (
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire tomasuloPkg::instrWord instr,
	output logic creditReturn,
	output tomasuloPkg::cdbResult result,
	input wire tomasuloPkg::regIndex regAddr,
	output tomasuloPkg::dataWord regData
);

	tomasuloPkg::issuePacket issue;
	logic [tomasuloPkg::NUM_STATIONS-1:0] freeMask;
	tomasuloPkg::execPacket dispatch;
	tomasuloPkg::cdbResult cdb; // common data bus

	issueRename issueStage (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.freeMask(freeMask),
		.cdb(cdb),
		.issue(issue),
		.regAddr(regAddr),
		.regData(regData)
	);

	resStation stations (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.cdb(cdb),
		.freeMask(freeMask),
		.dispatch(dispatch),
		.creditReturn(creditReturn)
	);

	aluPipe alu (
		.clk(clk),
		.reset(reset),
		.dispatch(dispatch),
		.result(cdb)
	);

	assign result = cdb;

endmodule

`default_nettype wire

//--- sim/tomasuloTb.sv
`default_nettype none

module tomasuloTb;

	localparam int RANDOM_COUNT = 200;
	localparam int CHAIN_COUNT = 10;
	// each instruction gets the worst case of a full station turnaround, plus slack
	localparam int CYCLE_LIMIT =
		(RANDOM_COUNT + CHAIN_COUNT + 1) * tomasuloPkg::NUM_STATIONS * 8 + 300;

	typedef struct packed {
		tomasuloPkg::regIndex rd;
		tomasuloPkg::dataWord value;
	} expectedResult;

	logic clk;
	logic reset;
	logic instrValid;
	tomasuloPkg::instrWord instr;
	logic creditReturn;
	tomasuloPkg::cdbResult result;
	tomasuloPkg::regIndex regAddr;
	tomasuloPkg::dataWord regData;

	expectedResult pending [$]; // in-order results not yet seen on the bus
	tomasuloPkg::dataWord modelRegs [tomasuloPkg::NUM_REGS];
	logic [31:0] lcgState = 32'd86270;
	int credits = tomasuloPkg::NUM_STATIONS;
	int sent = 0;
	int returned = 0;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int testsRun = 0;

	tomasuloCore uut (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.creditReturn(creditReturn),
		.result(result),
		.regAddr(regAddr),
		.regData(regData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// stops a hung run
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles, %0d results still outstanding",
			cycles, pending.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic logic [15:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16]; // upper bits have the longer period
	endfunction

	function automatic tomasuloPkg::instrWord regInstr(input tomasuloPkg::opCode op,
			input tomasuloPkg::regIndex rd, input tomasuloPkg::regIndex rs,
			input tomasuloPkg::regIndex rt);
		tomasuloPkg::instrWord w;
		w.rType.op = op;
		w.rType.rd = rd;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.unused = '0;
		return w;
	endfunction

	function automatic tomasuloPkg::instrWord immInstr(input tomasuloPkg::regIndex rd,
			input tomasuloPkg::regIndex rs, input logic [7:0] imm);
		tomasuloPkg::instrWord w;
		w.iType.op = tomasuloPkg::OP_ADDI;
		w.iType.rd = rd;
		w.iType.rs = rs;
		w.iType.imm = imm;
		return w;
	endfunction

	function automatic tomasuloPkg::instrWord randomInstr();
		logic [15:0] r;
		r = nextRandom();
		if (r[1:0] == tomasuloPkg::OP_ADDI) begin
			return immInstr(r[4:2], r[7:5], r[15:8]);
		end else begin
			return regInstr(r[1:0], r[4:2], r[7:5], r[10:8]);
		end
	endfunction

	// in-order interpretation against the model registers
	function automatic tomasuloPkg::dataWord modelResult(input tomasuloPkg::instrWord w);
		tomasuloPkg::dataWord a;
		tomasuloPkg::dataWord b;
		logic [31:0] full;
		a = modelRegs[w.rType.rs];
		b = modelRegs[w.rType.rt];
		full = a * b;
		case (w.rType.op)
			tomasuloPkg::OP_ADD: return a + b;
			tomasuloPkg::OP_SUB: return a - b;
			tomasuloPkg::OP_MUL: return full[15:0];
			default: return a + {8'h00, w.iType.imm};
		endcase
	endfunction

	// one clock: sample the core at the falling edge, then release instrValid
	task automatic tick();
		int idx;
		@(negedge clk);
		if (result.valid) begin
			idx = -1;
			for (int i = 0; i < pending.size(); i++) begin
				if (idx < 0 && pending[i].rd == result.rd
						&& pending[i].value == result.value) begin
					idx = i;
				end
			end
			checks++;
			assert (idx >= 0) else begin
				$display("ERR %0t: result r%0d = %h (tag %0d) matches no pending instruction",
					$time, result.rd, result.value, result.tag);
				errors++;
			end
			if (idx >= 0) begin
				pending.delete(idx);
			end
		end
		if (creditReturn) begin
			credits++;
			returned++;
			checks++;
			assert (credits <= tomasuloPkg::NUM_STATIONS) else begin
				$display("ERR %0t: credit returned with none outstanding (counter at %0d)",
					$time, credits);
				errors++;
			end
		end
		instrValid = 1'b0;
	endtask

	task automatic sendInstr(input tomasuloPkg::instrWord w);
		expectedResult e;
		tick();
		instrValid = 1'b1;
		instr = w;
		e.rd = w.rType.rd;
		e.value = modelResult(w);
		modelRegs[e.rd] = e.value;
		pending.push_back(e);
		credits--;
		sent++;
	endtask

	task automatic sendWhenCredit(input tomasuloPkg::instrWord w);
		while (credits == 0) begin
			tick();
		end
		sendInstr(w);
	endtask

	task automatic waitDrain();
		while (credits != tomasuloPkg::NUM_STATIONS) begin
			tick();
		end
		repeat (4) tick(); // nothing may follow the drain
		checks++;
		assert (pending.size() == 0) else begin
			$display("ERR %0t: %0d results never arrived", $time, pending.size());
			errors++;
		end
	endtask

	// one register per cycle through the debug port
	task automatic compareRegisters();
		tomasuloPkg::dataWord expected;
		for (int r = 0; r <= tomasuloPkg::NUM_REGS; r++) begin
			tick();
			if (r > 0) begin
				expected = modelRegs[r-1];
				checks++;
				assert (regData == expected) else begin
					$display("ERR %0t: r%0d expected %h, read %h", $time, r - 1, expected, regData);
					errors++;
				end
			end
			if (r < tomasuloPkg::NUM_REGS) begin
				regAddr = tomasuloPkg::regIndex'(r);
			end
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		$display("test %s: %0d errors", name, errors - errBefore);
		testsRun++;
	endtask

	initial begin
		int errBefore;
		int ticks;
		int numSent;
		logic sawResult;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		regAddr = '0;
		for (int r = 0; r < tomasuloPkg::NUM_REGS; r++) begin
			modelRegs[r] = '0;
		end

		errBefore = errors;
		repeat (4) begin
			tick();
			checks++;
			assert (!result.valid && !creditReturn) else begin
				$display("ERR %0t: result.valid or creditReturn high during reset", $time);
				errors++;
			end
		end
		reset = 1'b0;
		compareRegisters();
		checks++;
		assert (credits == tomasuloPkg::NUM_STATIONS) else begin
			$display("ERR %0t: credit returned while idle after reset", $time);
			errors++;
		end
		reportTest("resetState", errBefore);

		errBefore = errors;
		sendInstr(immInstr(3'd1, 3'd0, 8'h2a));
		ticks = 0;
		sawResult = 1'b0;
		while (!sawResult) begin
			tick();
			ticks++;
			sawResult = result.valid;
		end
		checks++;
		assert (ticks - 1 == 5) else begin // first edge only accepts the instruction
			$display("ERR %0t: isolated result after %0d cycles, expected 5", $time, ticks - 1);
			errors++;
		end
		checks++;
		assert (result.tag == '0) else begin // idle core allocates the lowest entry
			$display("ERR %0t: isolated result carried tag %0d, expected 0", $time, result.tag);
			errors++;
		end
		waitDrain();
		reportTest("isolatedLatency", errBefore);

		errBefore = errors;
		sendWhenCredit(immInstr(3'd2, 3'd1, 8'h13));
		sendWhenCredit(regInstr(tomasuloPkg::OP_MUL, 3'd3, 3'd2, 3'd1));
		sendWhenCredit(regInstr(tomasuloPkg::OP_SUB, 3'd4, 3'd3, 3'd2));
		sendWhenCredit(regInstr(tomasuloPkg::OP_MUL, 3'd5, 3'd4, 3'd4));
		sendWhenCredit(immInstr(3'd6, 3'd5, 8'hff));
		sendWhenCredit(regInstr(tomasuloPkg::OP_ADD, 3'd7, 3'd6, 3'd3));
		sendWhenCredit(regInstr(tomasuloPkg::OP_MUL, 3'd2, 3'd7, 3'd5));
		sendWhenCredit(regInstr(tomasuloPkg::OP_SUB, 3'd1, 3'd2, 3'd6));
		sendWhenCredit(immInstr(3'd3, 3'd1, 8'h80));
		sendWhenCredit(regInstr(tomasuloPkg::OP_MUL, 3'd4, 3'd3, 3'd2));
		waitDrain();
		reportTest("dependentChain", errBefore);

		errBefore = errors;
		numSent = 0;
		while (numSent < RANDOM_COUNT) begin
			if (credits > 0 && (nextRandom() % 4) != 0) begin
				sendInstr(randomInstr());
				numSent++;
			end else begin
				tick();
			end
		end
		waitDrain();
		reportTest("randomResults", errBefore);

		errBefore = errors;
		checks++;
		assert (returned == sent && credits == tomasuloPkg::NUM_STATIONS) else begin
			$display("ERR %0t: %0d credits returned for %0d sent, counter at %0d",
				$time, returned, sent, credits);
			errors++;
		end
		reportTest("credits", errBefore);

		errBefore = errors;
		compareRegisters();
		reportTest("finalState", errBefore);

		$display("%0d tests, %0d checks, %0d errors, %0d instructions", testsRun, checks,
			errors, sent);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hdl/tomasuloPkg.sv
hdl/issueRename.sv
hdl/resStation.sv
hdl/aluPipe.sv
hdl/tomasuloCore.sv
sim/tomasuloTb.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module tomasuloTb -Mdir obj_dir

run: build
	./obj_dir/VtomasuloTb | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f build.f --top-module tomasuloTb

clean:
	rm -rf obj_dir $(LOG)
